// File: build.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_field_extract.sv
logic/rv_imm_op_gen.sv
logic/rv_decoder_top.sv
dv/rv_decoder_assertions.sv
dv/rv_decoder_tb.sv

// File: dv/rv_decoder_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_assertions
    import rv_decode_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input fetch_slot_t slot_in,
    input decoded_t    dec_out
);

    // Two register stages lie between the input slot and the output
    valid_latency: assert property (@(posedge clk) disable iff (!rst)
        $past(rst, 1) && $past(rst, 2) |-> dec_out.valid == $past(slot_in.valid, 2))
        else $error("dec_out.valid does not follow slot_in.valid by two cycles");

    invalid_clean: assert property (@(posedge clk) disable iff (!rst)
        dec_out.op == op_invalid |-> !dec_out.has_imm && dec_out.rs1 == '0
            && dec_out.rs2 == '0 && dec_out.rd == '0)
        else $error("op_invalid output carries nonzero fields or has_imm");

    reset_clears: assert property (@(posedge clk) !rst |=> !dec_out.valid)
        else $error("dec_out.valid is high on the edge after reset");

endmodule

bind rv_decoder_top rv_decoder_assertions rv_decoder_assertions_inst (
    .clk     (clk),
    .rst     (rst),
    .slot_in (slot_in),
    .dec_out (dec_out)
);

`default_nettype wire

// File: dv/rv_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_tb
    import rv_decode_pkg::*;
();

    localparam int total_instr = 10 + 9 + 8 + 17 + 4 + 20;

    typedef struct packed {
        decoded_t exp;
        int       due;
    } pending_t;

    logic        clk = 1'b0;
    logic        rst;
    fetch_slot_t slot_in;
    decoded_t    dec_out;

    pending_t pend_q[$];
    int       cycle;
    int       seed;
    int       errors;
    int       test_errors;
    int       tests_passed;
    int       tests_failed;
    string    cur_test = "reset";

    rv_decoder_top rv_decoder_top_inst (
        .clk     (clk),
        .rst     (rst),
        .slot_in (slot_in),
        .dec_out (dec_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        #((total_instr + 200) * 40);
        $display("ERROR: watchdog expired during %s, results stopped coming", cur_test);
        $display("TEST FAIL");
        $finish;
    end

    function automatic word_t r_word(logic [6:0] f7, funct3_t f3, int rs2, int rs1, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
    endfunction

    function automatic word_t i_word(int imm, funct3_t f3, int rs1, int rd, opcode_t opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t s_word(int imm, funct3_t f3, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_word(int off, funct3_t f3, int rs2, int rs1);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t u_word(logic [19:0] upper, int rd, opcode_t opc);
        return {upper, rd[4:0], opc};
    endfunction

    function automatic word_t j_word(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic decoded_t expect_dec(op_t op, int rs1, int rs2, int rd, int imm,
                                            logic has_imm);
        decoded_t d;
        d.valid   = 1'b1;
        d.op      = op;
        d.rs1     = reg_addr_t'(rs1);
        d.rs2     = reg_addr_t'(rs2);
        d.rd      = reg_addr_t'(rd);
        d.imm     = imm_t'(imm);
        d.has_imm = has_imm;
        return d;
    endfunction

    task automatic check_op(string name, op_t exp, op_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %s (%h), actual %s (%h)",
                     name, exp.name(), exp, act.name(), act);
            errors++;
        end
    endtask

    task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected x%0d, actual x%0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_imm(string name, imm_t exp, imm_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_result(decoded_t exp);
        check_op({cur_test, " op"}, exp.op, dec_out.op);
        check_reg({cur_test, " rs1"}, exp.rs1, dec_out.rs1);
        check_reg({cur_test, " rs2"}, exp.rs2, dec_out.rs2);
        check_reg({cur_test, " rd"}, exp.rd, dec_out.rd);
        check_imm({cur_test, " imm"}, exp.imm, dec_out.imm);
        check_flag({cur_test, " has_imm"}, exp.has_imm, dec_out.has_imm);
    endtask

    // Outputs are registered on the rising edge and read back on the falling one
    always @(negedge clk) begin
        if (dec_out.valid) begin
            if (pend_q.size() == 0) begin
                $display("ERROR %s: a result came out with no instruction pending", cur_test);
                errors++;
            end else begin
                if (pend_q[0].due != cycle) begin
                    $display("ERROR %s: result came in cycle %0d but was due in cycle %0d",
                             cur_test, cycle, pend_q[0].due);
                    errors++;
                end
                compare_result(pend_q[0].exp);
                void'(pend_q.pop_front());
            end
        end else if (pend_q.size() != 0 && pend_q[0].due <= cycle) begin
            $display("ERROR %s: no result came out two cycles after its instruction", cur_test);
            errors++;
            void'(pend_q.pop_front());
        end
    end

    task automatic send_instr(word_t w, decoded_t exp);
        pending_t p;
        @(posedge clk);
        slot_in <= {1'b1, w};
        p.exp = exp;
        p.due = cycle + 3;
        pend_q.push_back(p);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            slot_in.valid <= 1'b0;
        end
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        idle_cycles(1);
        while (pend_q.size() != 0) begin
            @(posedge clk);
        end
        $display("%s finished with %0d errors", cur_test, errors - test_errors);
        if (errors == test_errors) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    task automatic reset_midstream();
        @(posedge clk);
        slot_in.valid <= 1'b0;
        rst <= 1'b0;
        // Whatever has not reached the output register by the next edge is lost
        while (pend_q.size() != 0 && pend_q[$].due > cycle + 1) begin
            void'(pend_q.pop_back());
        end
        @(posedge clk);
        @(negedge clk);
        check_flag({cur_test, " valid in reset"}, 1'b0, dec_out.valid);
        check_op({cur_test, " op in reset"}, op_invalid, dec_out.op);
        @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic reg_alu_ops();
        op_t ops[8] = '{op_add, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and};
        begin_test("reg_alu");
        for (int i = 0; i < 8; i++) begin
            send_instr(r_word(7'b0000000, funct3_t'(i), i + 9, i + 1, i + 17),
                       expect_dec(ops[i], i + 1, i + 9, i + 17, 0, 1'b0));
        end
        send_instr(r_word(7'b0100000, 3'b000, 31, 30, 29), expect_dec(op_sub, 30, 31, 29, 0, 1'b0));
        send_instr(r_word(7'b0100000, 3'b101, 2, 3, 4), expect_dec(op_sra, 3, 2, 4, 0, 1'b0));
        end_test();
    endtask

    task automatic imm_alu_ops();
        funct3_t f3s[6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
        int      imms[6] = '{-5, -2048, -1, -100, -300, -16};
        op_t     ops[6] = '{op_add, op_slt, op_sltu, op_xor, op_or, op_and};
        begin_test("imm_alu");
        for (int i = 0; i < 6; i++) begin
            send_instr(i_word(imms[i], f3s[i], i + 3, i + 20, opc_op_imm),
                       expect_dec(ops[i], i + 3, 0, i + 20, imms[i], 1'b1));
        end
        // Shift amounts come out zero-extended without the funct7 bits
        send_instr(i_word(7, 3'b001, 1, 2, opc_op_imm), expect_dec(op_sll, 1, 0, 2, 7, 1'b1));
        send_instr(i_word(31, 3'b101, 3, 4, opc_op_imm), expect_dec(op_srl, 3, 0, 4, 31, 1'b1));
        send_instr(i_word(1024 + 13, 3'b101, 5, 6, opc_op_imm),
                   expect_dec(op_sra, 5, 0, 6, 13, 1'b1));
        end_test();
    endtask

    task automatic load_store_ops();
        funct3_t ld_f3[5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        op_t     ld_ops[5] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu};
        int      ld_offs[5] = '{-1, -2048, 2047, -64, 8};
        op_t     st_ops[3] = '{op_sb, op_sh, op_sw};
        int      st_offs[3] = '{-4, -2048, 1000};
        begin_test("load_store");
        for (int i = 0; i < 5; i++) begin
            send_instr(i_word(ld_offs[i], ld_f3[i], 10 + i, 15 + i, opc_load),
                       expect_dec(ld_ops[i], 10 + i, 0, 15 + i, ld_offs[i], 1'b1));
        end
        for (int i = 0; i < 3; i++) begin
            send_instr(s_word(st_offs[i], funct3_t'(i), 20 + i, 25 + i),
                       expect_dec(st_ops[i], 25 + i, 20 + i, 0, st_offs[i], 1'b1));
        end
        end_test();
    endtask

    task automatic control_transfer();
        funct3_t br_f3[6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        op_t     br_ops[6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        int      off;
        begin_test("control");
        // Each branch is sent once with a positive and once with a negative even offset
        for (int i = 0; i < 12; i++) begin
            off = $random(seed) & 'hffe;
            if (i % 2 == 1) begin
                off = -off - 2;
            end
            send_instr(b_word(off, br_f3[i / 2], i + 1, i + 2),
                       expect_dec(br_ops[i / 2], i + 2, i + 1, 0, off, 1'b1));
        end
        for (int i = 0; i < 2; i++) begin
            off = $random(seed) & 'hffffe;
            if (i == 1) begin
                off = -off - 2;
            end
            send_instr(j_word(off, 1), expect_dec(op_jal, 0, 0, 1, off, 1'b1));
        end
        send_instr(i_word(-12, 3'b000, 5, 1, opc_jalr), expect_dec(op_jalr, 5, 0, 1, -12, 1'b1));
        send_instr(u_word(20'hdead5, 3, opc_lui), expect_dec(op_lui, 0, 0, 3, 32'hdead5000, 1'b1));
        send_instr(u_word(20'h00012, 4, opc_auipc),
                   expect_dec(op_auipc, 0, 0, 4, 32'h00012000, 1'b1));
        end_test();
    endtask

    task automatic illegal_words();
        begin_test("illegal");
        send_instr(32'h0000_0000, expect_dec(op_invalid, 0, 0, 0, 0, 1'b0));
        send_instr({25'h0a5a5a5, 7'b0001011}, expect_dec(op_invalid, 0, 0, 0, 0, 1'b0));
        send_instr(b_word(8, 3'b010, 2, 3), expect_dec(op_invalid, 0, 0, 0, 0, 1'b0));
        send_instr(r_word(7'b0000001, 3'b000, 4, 5, 6), expect_dec(op_invalid, 0, 0, 0, 0, 1'b0));
        end_test();
    endtask

    task automatic streaming_burst();
        int imm;
        int rs1;
        int rd;
        begin_test("streaming");
        for (int i = 0; i < 19; i++) begin
            imm = $random(seed) % 2048;
            rs1 = $random(seed) & 31;
            rd = $random(seed) & 31;
            if (i % 2 == 0) begin
                send_instr(i_word(imm, 3'b000, rs1, rd, opc_op_imm),
                           expect_dec(op_add, rs1, 0, rd, imm, 1'b1));
            end else begin
                send_instr(i_word(imm, 3'b010, rs1, rd, opc_load),
                           expect_dec(op_lw, rs1, 0, rd, imm, 1'b1));
            end
            if (i < 15) begin
                idle_cycles($random(seed) & 3);
            end
        end
        reset_midstream();
        send_instr(r_word(7'b0100000, 3'b000, 7, 8, 9), expect_dec(op_sub, 8, 7, 9, 0, 1'b0));
        end_test();
    endtask

    initial begin
        seed = 5012;
        rst <= 1'b0;
        slot_in <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        reg_alu_ops();
        imm_alu_ops();
        load_store_ops();
        control_transfer();
        illegal_words();
        streaming_burst();
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Instruction word and immediate width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// Micro-op code width
`define RV_OP_W 5

`endif

// File: logic/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    `include "rv_decode_config.svh"

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_XLEN-1:0]       imm_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0]                funct3_t;

    // Major opcodes of the RV32I base set
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_t;

    typedef enum logic [`RV_OP_W-1:0] {
        op_add     = 5'b00000,
        op_and     = 5'b00001,
        op_or      = 5'b00010,
        op_sll     = 5'b00011,
        op_srl     = 5'b00100,
        op_slt     = 5'b00101,
        op_sltu    = 5'b00110,
        op_sra     = 5'b00111,
        op_sub     = 5'b01000,
        op_xor     = 5'b01001,
        op_beq     = 5'b01010,
        op_bge     = 5'b01011,
        op_bne     = 5'b01100,
        op_bgeu    = 5'b01101,
        op_lui     = 5'b01110,
        op_auipc   = 5'b01111,
        op_jal     = 5'b10000,
        op_jalr    = 5'b10001,
        op_lb      = 5'b10010,
        op_lh      = 5'b10011,
        op_lw      = 5'b10100,
        op_lbu     = 5'b10101,
        op_lhu     = 5'b10110,
        op_sb      = 5'b10111,
        op_sh      = 5'b11000,
        op_sw      = 5'b11001,
        op_blt     = 5'b11010,
        op_bltu    = 5'b11011,
        op_invalid = 5'b11111
    } op_t;

    // Format as classified by the first stage, illegal words included
    typedef enum logic [3:0] {
        fmt_r,
        fmt_i_alu,
        fmt_shift,
        fmt_load,
        fmt_store,
        fmt_branch,
        fmt_lui,
        fmt_auipc,
        fmt_jal,
        fmt_jalr,
        fmt_illegal
    } fmt_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
    } fetch_slot_t;

    typedef struct packed {
        logic      valid;
        fmt_t      fmt;
        funct3_t   funct3;
        logic      alt;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     instr;
    } fields_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        imm_t      imm;
        logic      has_imm;
    } decoded_t;

endpackage

`default_nettype wire

// File: logic/rv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_slot_t slot_in,
    output decoded_t    dec_out
);

    // Registered stage-one result
    fields_t fields;

    rv_field_extract rv_field_extract_inst (
        .clk     (clk),
        .rst     (rst),
        .slot_in (slot_in),
        .fields  (fields)
    );

    rv_imm_op_gen rv_imm_op_gen_inst (
        .clk     (clk),
        .rst     (rst),
        .fields  (fields),
        .dec_out (dec_out)
    );

endmodule

`default_nettype wire

// File: logic/rv_field_extract.sv
`timescale 1ns/1ps
`default_nettype none

module rv_field_extract
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_slot_t slot_in,
    output fields_t     fields
);

    word_t      instr;
    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    fmt_t       fmt;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;

    assign instr   = slot_in.instr;
    assign opcode  = opcode_t'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // An all-zero word has opcode 0000000 and falls to the default arm
    always_comb begin
        fmt = fmt_illegal;
        case (opcode)
            opc_lui:    fmt = fmt_lui;
            opc_auipc:  fmt = fmt_auipc;
            opc_jal:    fmt = fmt_jal;
            opc_jalr:   fmt = fmt_jalr;
            opc_branch: fmt = (funct3[2:1] == 2'b01) ? fmt_illegal : fmt_branch;
            opc_load:   fmt = (funct3 inside {3'b011, 3'b110, 3'b111}) ? fmt_illegal : fmt_load;
            opc_store:  fmt = (funct3[2] || funct3 == 3'b011) ? fmt_illegal : fmt_store;
            opc_op_imm: begin
                if (funct3 == 3'b001) begin
                    fmt = f7_zero ? fmt_shift : fmt_illegal;
                end else if (funct3 == 3'b101) begin
                    fmt = (f7_zero || f7_alt) ? fmt_shift : fmt_illegal;
                end else begin
                    fmt = fmt_i_alu;
                end
            end
            opc_op: begin
                // Only SUB and SRA may carry the alternate funct7
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    fmt = fmt_r;
                end
            end
            default:    fmt = fmt_illegal;
        endcase
    end

    // Zero the register fields a format does not use
    always_comb begin
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        rd  = instr[11:7];
        case (fmt)
            fmt_r: ;
            fmt_i_alu, fmt_shift, fmt_load, fmt_jalr: rs2 = '0;
            fmt_store, fmt_branch: rd = '0;
            fmt_lui, fmt_auipc, fmt_jal: begin
                rs1 = '0;
                rs2 = '0;
            end
            default: begin
                rs1 = '0;
                rs2 = '0;
                rd  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fields.valid <= 1'b0;
        end else begin
            fields.valid <= slot_in.valid;
            if (slot_in.valid) begin
                fields.fmt    <= fmt;
                fields.funct3 <= funct3;
                fields.alt    <= instr[30];
                fields.rs1    <= rs1;
                fields.rs2    <= rs2;
                fields.rd     <= rd;
                fields.instr  <= instr;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_imm_op_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_op_gen
    import rv_decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  fields_t  fields,
    output decoded_t dec_out
);

    word_t instr;
    imm_t  imm;
    op_t   op;
    logic  has_imm;

    assign instr = fields.instr;

    // Shared ALU mapping for R-type, I-type and shifts
    function automatic op_t alu_op(input funct3_t f3, input logic alt);
        op_t result;
        case (f3)
            3'b000:  result = alt ? op_sub : op_add;
            3'b001:  result = op_sll;
            3'b010:  result = op_slt;
            3'b011:  result = op_sltu;
            3'b100:  result = op_xor;
            3'b101:  result = alt ? op_sra : op_srl;
            3'b110:  result = op_or;
            default: result = op_and;
        endcase
        return result;
    endfunction

    always_comb begin
        case (fields.fmt)
            fmt_i_alu, fmt_load, fmt_jalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            fmt_shift:
                imm = {27'b0, instr[24:20]};
            fmt_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            fmt_branch:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            fmt_lui, fmt_auipc:
                imm = {instr[31:12], 12'b0};
            fmt_jal:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        op = op_invalid;
        case (fields.fmt)
            fmt_r:     op = alu_op(fields.funct3, fields.alt);
            // Bit 30 belongs to the immediate here, so it never selects SUB
            fmt_i_alu: op = alu_op(fields.funct3, 1'b0);
            fmt_shift: op = alu_op(fields.funct3, fields.alt);
            fmt_load: begin
                case (fields.funct3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    default: op = op_invalid;
                endcase
            end
            fmt_store: begin
                case (fields.funct3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    default: op = op_invalid;
                endcase
            end
            fmt_branch: begin
                case (fields.funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_invalid;
                endcase
            end
            fmt_lui:   op = op_lui;
            fmt_auipc: op = op_auipc;
            fmt_jal:   op = op_jal;
            fmt_jalr:  op = op_jalr;
            default:   op = op_invalid;
        endcase
    end

    assign has_imm = !(fields.fmt == fmt_r || fields.fmt == fmt_illegal);

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_out.valid   <= 1'b0;
            dec_out.op      <= op_invalid;
            dec_out.rs1     <= '0;
            dec_out.rs2     <= '0;
            dec_out.rd      <= '0;
            dec_out.imm     <= '0;
            dec_out.has_imm <= 1'b0;
        end else begin
            dec_out.valid <= fields.valid;
            if (fields.valid) begin
                dec_out.op      <= op;
                dec_out.rs1     <= fields.rs1;
                dec_out.rs2     <= fields.rs2;
                dec_out.rd      <= fields.rd;
                dec_out.imm     <= imm;
                dec_out.has_imm <= has_imm;
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module rv_decoder_tb \
    -o rv_decoder_sim || exit 1
result=$(./obj_dir/rv_decoder_sim)
echo "$result"
echo "$result" | grep -qx "TEST PASS" && exit 0 || exit 1
